//--- logic/buf_cfg.svh
// buffer sizes; BUF_DW must be a multiple of 8 and BUF_DEPTH must equal 2**BUF_AW.
`ifndef BUF_CFG_SVH
`define BUF_CFG_SVH

// number of words in the RAM.
`define BUF_DEPTH 64

// word width in bits.
`define BUF_DW 32

// word address width.
`define BUF_AW 6

// byte lanes per word.
`define BUF_SEL_W (`BUF_DW / 8)

`endif

//--- logic/mem_pkg.sv
// RAM word, address and byte-select types; widths follow buf_cfg.svh and are fixed at compile time.
`default_nettype none

`include "buf_cfg.svh"

package mem_pkg;

  // one RAM word.
  typedef logic [`BUF_DW-1:0] mem_word_t;

  // word address, no byte offset.
  typedef logic [`BUF_AW-1:0] mem_addr_t;

  // one enable per byte lane, lane 0 is bits 7:0.
  typedef logic [`BUF_SEL_W-1:0] mem_sel_t;

endpackage : mem_pkg

`default_nettype wire

//--- logic/wb_pkg.sv
// wishbone classic cycle states for the two single-direction port stages; no burst or error states.
`default_nettype none

package wb_pkg;

  // write port, one RAM write per cycle.
  typedef enum logic {
    w_idle,
    w_ack    // ack cycle, stb still held by the master.
  } wr_state_e;

  // read port.
  typedef enum logic [1:0] {
    r_idle,
    r_data,  // read granted, RAM data valid next edge.
    r_ack
  } rd_state_e;

endpackage : wb_pkg

`default_nettype wire

//--- logic/mem_port_if.sv
// stage-to-RAM links; a write lands on the edge where en is high, a read is taken when req and grant are high.
`timescale 1ns/100ps
`default_nettype none

// write path, driven entirely by the write stage.
interface mem_wr_if;
  import mem_pkg::*;

  logic      en;
  mem_addr_t addr;
  mem_word_t data;
  mem_sel_t  sel;  // only enabled lanes are written.

  modport stage (
    output en,
    output addr,
    output data,
    output sel
  );

  modport ram (
    input en,
    input addr,
    input data,
    input sel
  );
endinterface : mem_wr_if

// read path; grant drops only on a same-address write.
interface mem_rd_if;
  import mem_pkg::*;

  logic      req;
  mem_addr_t addr;
  logic      grant;
  mem_word_t data;  // valid from the cycle after an accepted read.

  modport stage (
    output req,
    output addr,
    input  grant,
    input  data
  );

  modport ram (
    input  req,
    input  addr,
    output grant,
    output data
  );
endinterface : mem_rd_if

`default_nettype wire

//--- logic/wb_write_stage.sv
// write-only wishbone classic slave; master must drop stb for a cycle after ack, no err, rty or bursts.
`timescale 1ns/100ps
`default_nettype none

module wb_write_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cyc,
  input  logic               stb,
  input  mem_pkg::mem_addr_t adr,
  input  mem_pkg::mem_word_t dat,
  input  mem_pkg::mem_sel_t  sel,
  output logic               ack,
  mem_wr_if.stage            mem
);
  import wb_pkg::*;

  wr_state_e state;
  wr_state_e state_nxt;
  logic      wr_go;

  // the RAM takes the write on the same edge stb is first seen.
  assign wr_go = (state == w_idle) && cyc && stb;

  assign mem.en   = wr_go;
  assign mem.addr = adr;
  assign mem.data = dat;
  assign mem.sel  = sel;

  always_comb begin
    state_nxt = state;
    case (state)
      w_idle: begin
        if (wr_go) begin
          state_nxt = w_ack;
        end
      end
      w_ack: begin
        state_nxt = w_idle;  // stb is still up here, so no second write.
      end
      default: begin
        state_nxt = w_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= w_idle;
      ack   <= 1'b0;
    end else begin
      state <= state_nxt;
      ack   <= wr_go;  // exactly one cycle, right after the write edge.
    end
  end

endmodule : wb_write_stage

`default_nettype wire

//--- logic/dp_ram.sv
// write-first dual-port RAM, port A reads and port B writes; contents are not reset and start unknown.
`timescale 1ns/100ps
`default_nettype none

`include "buf_cfg.svh"

module dp_ram (
  input  logic   clk,
  input  logic   rst_n,
  mem_wr_if.ram  wr,
  mem_rd_if.ram  rd
);
  import mem_pkg::*;

  mem_word_t mem_r [`BUF_DEPTH];
  mem_addr_t addr_r;   // address of the last accepted read.
  logic      collide;
  logic      rd_take;

  // a read of the word being written this cycle waits one cycle
  // so that it sees the new value.
  assign collide  = wr.en && (wr.addr == rd.addr);
  assign rd.grant = !collide;

  assign rd_take = rd.req && rd.grant;

  // byte-masked write.
  always_ff @(posedge clk) begin
    if (wr.en) begin
      for (int i = 0; i < `BUF_SEL_W; i++) begin
        if (wr.sel[i]) begin
          mem_r[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr_r <= '0;
    end else if (rd_take) begin
      addr_r <= rd.addr;
    end
  end

  // read straight from the array at the registered address.
  // a later write to that word shows up here too, the stage samples it once.
  assign rd.data = mem_r[addr_r];

endmodule : dp_ram

`default_nettype wire

//--- logic/wb_read_stage.sv
// read-only wishbone classic slave; latency 2 cycles plus one per collision, no err, rty or bursts.
`timescale 1ns/100ps
`default_nettype none

module wb_read_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cyc,
  input  logic               stb,
  input  mem_pkg::mem_addr_t adr,
  output mem_pkg::mem_word_t dat,
  output logic               ack,
  mem_rd_if.stage            mem
);
  import wb_pkg::*;

  rd_state_e state;
  rd_state_e state_nxt;
  logic      rd_req;

  assign rd_req   = (state == r_idle) && cyc && stb;
  assign mem.req  = rd_req;
  assign mem.addr = adr;

  always_comb begin
    state_nxt = state;
    case (state)
      r_idle: begin
        // stay here while a same-address write blocks the read.
        if (rd_req && mem.grant) begin
          state_nxt = r_data;
        end
      end
      r_data: begin
        state_nxt = r_ack;
      end
      r_ack: begin
        state_nxt = r_idle;
      end
      default: begin
        state_nxt = r_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= r_idle;
      ack   <= 1'b0;
    end else begin
      state <= state_nxt;
      ack   <= (state == r_data);  // high for the r_ack cycle only.
    end
  end

  // hold the word so a later write to it cannot change dat under ack.
  always_ff @(posedge clk) begin
    if (state == r_data) begin
      dat <= mem.data;
    end
  end

endmodule : wb_read_stage

`default_nettype wire

//--- logic/dp_buffer_top.sv
// two-port word buffer, one write-only and one read-only wishbone classic slave; no we, err, rty or tags.
`timescale 1ns/100ps
`default_nettype none

module dp_buffer_top (
  input  logic               clk,
  input  logic               rst_n,

  // write port.
  input  logic               wbw_cyc,
  input  logic               wbw_stb,
  input  mem_pkg::mem_addr_t wbw_adr,
  input  mem_pkg::mem_word_t wbw_dat,
  input  mem_pkg::mem_sel_t  wbw_sel,
  output logic               wbw_ack,

  // read port.
  input  logic               wbr_cyc,
  input  logic               wbr_stb,
  input  mem_pkg::mem_addr_t wbr_adr,
  output mem_pkg::mem_word_t wbr_dat,
  output logic               wbr_ack
);

  mem_wr_if wr_if ();
  mem_rd_if rd_if ();

  wb_write_stage u_write (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (wbw_cyc),
    .stb   (wbw_stb),
    .adr   (wbw_adr),
    .dat   (wbw_dat),
    .sel   (wbw_sel),
    .ack   (wbw_ack),
    .mem   (wr_if.stage)
  );

  dp_ram u_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr_if.ram),
    .rd    (rd_if.ram)
  );

  wb_read_stage u_read (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (wbr_cyc),
    .stb   (wbr_stb),
    .adr   (wbr_adr),
    .dat   (wbr_dat),
    .ack   (wbr_ack),
    .mem   (rd_if.stage)
  );

endmodule : dp_buffer_top

`default_nettype wire

//--- test/buffer_tb.sv
// testbench for dp_buffer_top; stimulus comes from a 32-bit galois lfsr with seed 48, so runs repeat.
`timescale 1ns/100ps
`default_nettype none

`include "buf_cfg.svh"

module buffer_tb;
  import mem_pkg::*;

  localparam int n_ops      = 2 * `BUF_DEPTH + 64 + 8 + 200;
  localparam int max_cycles = n_ops * 6 + 100;

  logic      clk;
  logic      rst_n;
  logic      wbw_cyc;
  logic      wbw_stb;
  mem_addr_t wbw_adr;
  mem_word_t wbw_dat;
  mem_sel_t  wbw_sel;
  logic      wbw_ack;
  logic      wbr_cyc;
  logic      wbr_stb;
  mem_addr_t wbr_adr;
  mem_word_t wbr_dat;
  logic      wbr_ack;

  mem_word_t   model [`BUF_DEPTH];
  logic        model_vld [`BUF_DEPTH];  // word has been fully written.
  logic [31:0] lfsr;
  logic        wr_busy;      // a write reaches the RAM on the next edge.
  mem_addr_t   wr_busy_adr;
  int          cycles;
  int          checks;
  int          errors;
  int          mark;
  mem_addr_t   wq_adr [$];
  mem_word_t   wq_dat [$];
  mem_sel_t    wq_sel [$];
  mem_addr_t   rq_adr [$];
  mem_addr_t   a;
  mem_word_t   d;
  mem_sel_t    s;

  dp_buffer_top dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run stopped, no progress after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // merge the enabled byte lanes into the reference word.
  function automatic void apply_write(input mem_addr_t wa, input mem_word_t wd, input mem_sel_t ws);
    for (int i = 0; i < `BUF_SEL_W; i++) begin
      if (ws[i]) model[wa][8*i +: 8] = wd[8*i +: 8];
    end
    if (ws == '1) begin
      model_vld[wa] = 1'b1;
    end
  endfunction

  task automatic fail_msg(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic write_word(input mem_addr_t wa, input mem_word_t wd, input mem_sel_t ws);
    @(posedge clk);
    wbw_cyc <= 1'b1;
    wbw_stb <= 1'b1;
    wbw_adr <= wa;
    wbw_dat <= wd;
    wbw_sel <= ws;
    wr_busy     = 1'b1;
    wr_busy_adr = wa;
    @(negedge clk);
    checks++;
    if (wbw_ack) fail_msg($sformatf("write to %h acked before the write edge", wa));
    @(posedge clk);  // the RAM takes the write here.
    wr_busy = 1'b0;
    apply_write(wa, wd, ws);
    @(negedge clk);
    checks++;
    if (!wbw_ack) fail_msg($sformatf("write to %h not acked one cycle after stb", wa));
    @(posedge clk);
    wbw_cyc <= 1'b0;
    wbw_stb <= 1'b0;
    @(negedge clk);
    checks++;
    if (wbw_ack) fail_msg($sformatf("write ack for %h held longer than one cycle", wa));
  endtask

  // lat_kind 0 wants exactly 2 cycles, 1 wants a collision stall, 2 takes any.
  task automatic read_word(input mem_addr_t ra, input int lat_kind);
    int        lat;
    logic      granted;
    mem_word_t expect_w;
    lat      = 0;
    granted  = 1'b0;
    expect_w = '0;
    @(posedge clk);
    wbr_cyc <= 1'b1;
    wbr_stb <= 1'b1;
    wbr_adr <= ra;
    @(negedge clk);
    while (!wbr_ack && lat < 16) begin
      if (!granted && !(wr_busy && wr_busy_adr == ra)) begin
        granted  = 1'b1;  // granted on the coming edge.
        expect_w = model[ra];
      end
      @(negedge clk);
      lat++;
    end
    checks++;
    if (!wbr_ack) begin
      fail_msg($sformatf("read of %h was never acked", ra));
    end else if (!model_vld[ra]) begin
      fail_msg($sformatf("read of %h hit a word that was never fully written", ra));
    end else if (wbr_dat !== expect_w) begin
      fail_msg($sformatf("[ERROR] wbr_dat addr %h expected %h actual %h", ra, expect_w, wbr_dat));
    end
    if (lat_kind == 0 && lat != 2) begin
      fail_msg($sformatf("read of %h acked after %0d cycles instead of 2", ra, lat));
    end
    if (lat_kind == 1 && lat <= 2) begin
      fail_msg($sformatf("read of %h was not held by the write to the same word", ra));
    end
    @(posedge clk);
    wbr_cyc <= 1'b0;
    wbr_stb <= 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%s: %s, %0d errors", name, (errors == mark) ? "ok" : "FAILED", errors - mark);
    mark = errors;
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    {wbw_cyc, wbw_stb, wbr_cyc, wbr_stb} = '0;
    wbw_adr = '0;
    wbw_dat = '0;
    wbw_sel = '0;
    wbr_adr = '0;
    lfsr = 32'd48;
    wr_busy = 1'b0;
    wr_busy_adr = '0;
    foreach (model_vld[i]) model_vld[i] = 1'b0;
    {cycles, checks, errors, mark} = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    repeat (6) begin
      @(negedge clk);
      checks++;
      if (wbw_ack || wbr_ack) fail_msg("an ack went high with no cycle on the bus");
    end
    end_test("idle after reset");

    for (int i = 0; i < `BUF_DEPTH; i++) begin
      write_word(mem_addr_t'(i), rand_bits(`BUF_DW), '1);
    end
    for (int i = 0; i < `BUF_DEPTH; i++) read_word(mem_addr_t'(i), 0);
    end_test("fill and read back");

    for (int i = 0; i < 32; i++) begin
      wq_adr.push_back(mem_addr_t'(rand_bits(`BUF_AW)));
      write_word(wq_adr[i], rand_bits(`BUF_DW), mem_sel_t'(rand_bits(`BUF_SEL_W)));
    end
    foreach (wq_adr[i]) read_word(wq_adr[i], 0);
    wq_adr.delete();
    end_test("byte lanes");

    repeat (4) begin
      a = mem_addr_t'(rand_bits(`BUF_AW));
      d = rand_bits(`BUF_DW);
      s = mem_sel_t'(rand_bits(`BUF_SEL_W));
      fork
        write_word(a, d, s);
        read_word(a, 1);
      join
    end
    end_test("collision");

    // a narrow address window makes collisions likely.
    for (int i = 0; i < 200; i++) begin
      if (rand_bits(1)) begin
        wq_adr.push_back(mem_addr_t'(rand_bits(3)));
        wq_dat.push_back(rand_bits(`BUF_DW));
        wq_sel.push_back(mem_sel_t'(rand_bits(`BUF_SEL_W)));
      end else begin
        rq_adr.push_back(mem_addr_t'(rand_bits(3)));
      end
    end
    fork
      foreach (wq_adr[i]) write_word(wq_adr[i], wq_dat[i], wq_sel[i]);
      foreach (rq_adr[i]) read_word(rq_adr[i], 2);
    join
    end_test("random traffic");

    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : buffer_tb

`default_nettype wire

//--- tb.f
+incdir+logic
logic/mem_pkg.sv
logic/wb_pkg.sv
logic/mem_port_if.sv
logic/wb_write_stage.sv
logic/dp_ram.sv
logic/wb_read_stage.sv
logic/dp_buffer_top.sv
test/buffer_tb.sv
